// ==== vlog.f ====
+incdir+tests
logic/ControlPkg.sv
logic/SystemDecoder.sv
logic/AluOpDecoder.sv
logic/OpcodeDecoder.sv
logic/ControlRegister.sv
logic/ControlPipeM.sv
tests/ControlPipeMTb.sv

// ==== tests/ControlVectors.svh ====
// Columns: instruction word, flags {ecall, ebreak, invInstr, regWrite, csRegWrite,
// memWrite, memRead}, origA, origB, aluControl, mem2Reg, origPc, instrType
`ifndef CONTROL_VECTORS_SVH
`define CONTROL_VECTORS_SVH

localparam logic [6:0] FL_NONE   = 7'b0000000;
localparam logic [6:0] FL_MR     = 7'b0000001;
localparam logic [6:0] FL_MW     = 7'b0000010;
localparam logic [6:0] FL_CSR    = 7'b0000100;
localparam logic [6:0] FL_RW     = 7'b0001000;
localparam logic [6:0] FL_INV    = 7'b0010000;
localparam logic [6:0] FL_EBREAK = 7'b0100000;
localparam logic [6:0] FL_ECALL  = 7'b1000000;

localparam instrTypeT T_NONE   = '0;
localparam instrTypeT T_BRANCH = 9'b1 << ITYPE_BRANCH;
localparam instrTypeT T_JALR   = 9'b1 << ITYPE_JALR;
localparam instrTypeT T_JAL    = 9'b1 << ITYPE_JAL;
localparam instrTypeT T_I      = 9'b1 << ITYPE_TIPOI;
localparam instrTypeT T_R      = 9'b1 << ITYPE_TIPOR;
localparam instrTypeT T_STORE  = 9'b1 << ITYPE_STORE;
localparam instrTypeT T_LOAD   = 9'b1 << ITYPE_LOAD;
localparam instrTypeT T_RM     = T_R | (9'b1 << ITYPE_DIVREM);
localparam instrTypeT T_CSR    = 9'b1 << ITYPE_CSR;

task automatic fillVectors();
	addRow(32'h00412083, FL_RW | FL_MR,
		ORIGA_RS1, ORIGB_IMM, OPADD, MEM2REG_MEM, ORIGPC_NEXT, T_LOAD); // LW x1, 4(x2)
	addRow(32'h00312423, FL_MW,
		ORIGA_RS1, ORIGB_IMM, OPADD, MEM2REG_ALU, ORIGPC_NEXT, T_STORE); // SW x3, 8(x2)
	addRow(32'h123452B7, FL_RW,
		ORIGA_RS1, ORIGB_IMM, OPLUI, MEM2REG_ALU, ORIGPC_NEXT, T_I); // LUI
	addRow(32'h00001317, FL_RW,
		ORIGA_PC, ORIGB_IMM, OPADD, MEM2REG_ALU, ORIGPC_NEXT, T_I); // AUIPC
	addRow(32'h00208463, FL_NONE,
		ORIGA_RS1, ORIGB_RS2, OPADD, MEM2REG_ALU, ORIGPC_BRANCH, T_BRANCH); // BEQ
	addRow(32'h010000EF, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPADD, MEM2REG_PC4, ORIGPC_JAL, T_JAL);
	addRow(32'h000280E7, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPADD, MEM2REG_PC4, ORIGPC_JALR, T_JALR);
	addRow(32'h00510093, FL_RW,
		ORIGA_RS1, ORIGB_IMM, OPADD, MEM2REG_ALU, ORIGPC_NEXT, T_I); // ADDI
	addRow(32'hFFF12093, FL_RW,
		ORIGA_RS1, ORIGB_IMM, OPSLT, MEM2REG_ALU, ORIGPC_NEXT, T_I); // SLTI, negative imm
	addRow(32'h0FF17093, FL_RW,
		ORIGA_RS1, ORIGB_IMM, OPAND, MEM2REG_ALU, ORIGPC_NEXT, T_I); // ANDI
	addRow(32'h40315093, FL_RW,
		ORIGA_RS1, ORIGB_IMM, OPSRA, MEM2REG_ALU, ORIGPC_NEXT, T_I); // SRAI
	addRow(32'h003100B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPADD, MEM2REG_ALU, ORIGPC_NEXT, T_R); // ADD
	addRow(32'h403100B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPSUB, MEM2REG_ALU, ORIGPC_NEXT, T_R); // SUB
	addRow(32'h003110B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPSLL, MEM2REG_ALU, ORIGPC_NEXT, T_R); // SLL
	addRow(32'h403150B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPSRA, MEM2REG_ALU, ORIGPC_NEXT, T_R); // SRA
	addRow(32'h003170B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPAND, MEM2REG_ALU, ORIGPC_NEXT, T_R); // AND
	addRow(32'h023100B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPMUL, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h023110B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPMULH, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h023120B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPMULHSU, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h023130B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPMULHU, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h023140B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPDIV, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h023150B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPDIVU, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h023160B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPREM, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h023170B3, FL_RW,
		ORIGA_RS1, ORIGB_RS2, OPREMU, MEM2REG_ALU, ORIGPC_NEXT, T_RM);
	addRow(32'h00000073, FL_ECALL,
		ORIGA_RS1, ORIGB_RS2, OPNULL, MEM2REG_ALU, ORIGPC_UTVEC, T_NONE);
	addRow(32'h00100073, FL_EBREAK,
		ORIGA_RS1, ORIGB_RS2, OPNULL, MEM2REG_ALU, ORIGPC_NEXT, T_NONE);
	addRow(32'h00200073, FL_NONE,
		ORIGA_RS1, ORIGB_RS2, OPNULL, MEM2REG_ALU, ORIGPC_UEPC, T_NONE); // URET
	addRow(32'h300110F3, FL_RW | FL_CSR,
		ORIGA_RS1, ORIGB_ZERO, OPADD, MEM2REG_CSR, ORIGPC_NEXT, T_CSR); // CSRRW
	addRow(32'h300120F3, FL_RW | FL_CSR,
		ORIGA_RS1, ORIGB_RS2, OPOR, MEM2REG_CSR, ORIGPC_NEXT, T_CSR); // CSRRS
	addRow(32'h300130F3, FL_RW | FL_CSR,
		ORIGA_NOTRS1, ORIGB_RS2, OPAND, MEM2REG_CSR, ORIGPC_NEXT, T_CSR); // CSRRC
	addRow(32'h3002D0F3, FL_RW | FL_CSR,
		ORIGA_IMM, ORIGB_ZERO, OPADD, MEM2REG_CSR, ORIGPC_NEXT, T_CSR); // CSRRWI
	addRow(32'h3002E0F3, FL_RW | FL_CSR,
		ORIGA_IMM, ORIGB_RS2, OPOR, MEM2REG_CSR, ORIGPC_NEXT, T_CSR); // CSRRSI
	addRow(32'h3002F0F3, FL_RW | FL_CSR,
		ORIGA_IMM, ORIGB_RS2, OPAND, MEM2REG_CSR, ORIGPC_NEXT, T_CSR); // CSRRCI
	addInvalid(32'h203100B3); // Unknown funct7 on OP
	addInvalid(32'h00300073); // Bad funct12
	addInvalid(32'h00004073); // Unused SYSTEM funct3
endtask

`endif

// ==== tests/ControlPipeMTb.sv ====
`timescale 1ns/1ps

module ControlPipeMTb;
	import ControlPkg::*;

	localparam int RESET_CYCLES  = 5;
	localparam int RESET_TIMEOUT = 20;
	localparam int RANDOM_ROWS   = 12;

	logic      clock;
	logic      reset;
	instrT     instr;
	logic      ecall;
	logic      ebreak;
	logic      invInstr;
	logic      regWrite;
	logic      csRegWrite;
	logic      memWrite;
	logic      memRead;
	origAT     origA;
	origBT     origB;
	aluOpT     aluControl;
	mem2RegT   mem2Reg;
	origPcT    origPc;
	instrTypeT instrType;

	instrT      rowInstr[$];
	logic [6:0] rowFlags[$];
	origAT      rowOrigA[$];
	origBT      rowOrigB[$];
	aluOpT      rowAluOp[$];
	mem2RegT    rowMem2Reg[$];
	origPcT     rowOrigPc[$];
	instrTypeT  rowType[$];

	integer seed;
	int     currentRow;

	ControlPipeM ControlPipeM_inst
	(
		.clock      (clock),
		.reset      (reset),
		.instr      (instr),
		.ecall      (ecall),
		.ebreak     (ebreak),
		.invInstr   (invInstr),
		.regWrite   (regWrite),
		.csRegWrite (csRegWrite),
		.memWrite   (memWrite),
		.memRead    (memRead),
		.origA      (origA),
		.origB      (origB),
		.aluControl (aluControl),
		.mem2Reg    (mem2Reg),
		.origPc     (origPc),
		.instrType  (instrType)
	);

	always #2 clock = ~clock;

	// Reset held for the first cycles
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

	task automatic addRow(input instrT word, input logic [6:0] flags, input origAT a,
		input origBT b, input aluOpT op, input mem2RegT wb, input origPcT pc,
		input instrTypeT ty);
		rowInstr.push_back(word);
		rowFlags.push_back(flags);
		rowOrigA.push_back(a);
		rowOrigB.push_back(b);
		rowAluOp.push_back(op);
		rowMem2Reg.push_back(wb);
		rowOrigPc.push_back(pc);
		rowType.push_back(ty);
	endtask

	`include "ControlVectors.svh"

	// Invalid words leave only the flag set
	task automatic addInvalid(input instrT word);
		addRow(word, FL_INV, ORIGA_RS1, ORIGB_RS2, OPNULL, MEM2REG_ALU, ORIGPC_NEXT, T_NONE);
	endtask

	function automatic logic isKeptOpcode(input opcodeT op);
		return (op == OPC_SYSTEM) || (op == OPC_LOAD) || (op == OPC_OPIMM) ||
			(op == OPC_AUIPC) || (op == OPC_STORE) || (op == OPC_RTYPE) ||
			(op == OPC_LUI) || (op == OPC_BRANCH) || (op == OPC_JALR) || (op == OPC_JAL);
	endfunction

	task automatic addRandomRows(input int count);
		instrT word;
		for (int i = 0; i < count; i++)
		begin
			word = $random(seed);
			if (isKeptOpcode(word[6:0]))
				word[1:0] = 2'b00; // Every kept opcode ends in 11
			addInvalid(word);
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h (row %0d)",
			$time, name, expected, actual, currentRow);
		$display("Testbench failed");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			reportMismatch(name, 32'(expected), 32'(actual));
	endtask

	task automatic checkAluOp(input aluOpT expected, input aluOpT actual);
		if (actual !== expected)
			reportMismatch("aluControl", 32'(expected), 32'(actual));
	endtask

	task automatic checkOrigA(input origAT expected, input origAT actual);
		if (actual !== expected)
			reportMismatch("origA", 32'(expected), 32'(actual));
	endtask

	task automatic checkOrigB(input origBT expected, input origBT actual);
		if (actual !== expected)
			reportMismatch("origB", 32'(expected), 32'(actual));
	endtask

	task automatic checkMem2Reg(input mem2RegT expected, input mem2RegT actual);
		if (actual !== expected)
			reportMismatch("mem2Reg", 32'(expected), 32'(actual));
	endtask

	task automatic checkOrigPc(input origPcT expected, input origPcT actual);
		if (actual !== expected)
			reportMismatch("origPc", 32'(expected), 32'(actual));
	endtask

	task automatic checkInstrType(input instrTypeT expected, input instrTypeT actual);
		if (actual !== expected)
			reportMismatch("instrType", 32'(expected), 32'(actual));
	endtask

	task automatic checkOutputs(input logic [6:0] flags, input origAT a, input origBT b,
		input aluOpT op, input mem2RegT wb, input origPcT pc, input instrTypeT ty);
		checkBit("ecall", flags[6], ecall);
		checkBit("ebreak", flags[5], ebreak);
		checkBit("invInstr", flags[4], invInstr);
		checkBit("regWrite", flags[3], regWrite);
		checkBit("csRegWrite", flags[2], csRegWrite);
		checkBit("memWrite", flags[1], memWrite);
		checkBit("memRead", flags[0], memRead);
		checkOrigA(a, origA);
		checkOrigB(b, origB);
		checkAluOp(op, aluControl);
		checkMem2Reg(wb, mem2Reg);
		checkOrigPc(pc, origPc);
		checkInstrType(ty, instrType);
	endtask

	initial
	begin
		int waitCount;
		int rowCount;
		clock       = 1'b0;
		instr       = '0;
		seed        = 32'he2d78a8e;
		currentRow  = -1;
		fillVectors();
		addRandomRows(RANDOM_ROWS);
		rowCount = rowInstr.size();

		waitCount = 0;
		while (reset !== 1'b0)
		begin
			@(negedge clock);
			waitCount++;
			if (waitCount > RESET_TIMEOUT)
			begin
				$display("Reset was still high after %0d cycles", RESET_TIMEOUT);
				$display("Testbench failed");
				$fatal(1, "Reset timeout");
			end
		end
		checkOutputs('0, '0, '0, '0, '0, '0, '0); // Everything cleared by reset

		// One row per cycle, each checked after the next edge
		for (int i = 0; i <= rowCount; i++)
		begin
			@(posedge clock);
			if (i < rowCount)
				instr <= rowInstr[i];
			@(negedge clock);
			if (i > 0)
			begin
				currentRow = i - 1;
				checkOutputs(rowFlags[i - 1], rowOrigA[i - 1], rowOrigB[i - 1],
					rowAluOp[i - 1], rowMem2Reg[i - 1], rowOrigPc[i - 1], rowType[i - 1]);
			end
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== logic/ControlPipeM.sv ====
`timescale 1ns/1ps

module ControlPipeM
(
	input  logic                  clock,
	input  logic                  reset,
	input  ControlPkg::instrT     instr,
	output logic                  ecall,
	output logic                  ebreak,
	output logic                  invInstr,
	output logic                  regWrite,
	output logic                  csRegWrite,
	output logic                  memWrite,
	output logic                  memRead,
	output ControlPkg::origAT     origA,
	output ControlPkg::origBT     origB,
	output ControlPkg::aluOpT     aluControl,
	output ControlPkg::mem2RegT   mem2Reg,
	output ControlPkg::origPcT    origPc,
	output ControlPkg::instrTypeT instrType
);
	import ControlPkg::*;

	logic      nextEcall;
	logic      nextEbreak;
	logic      nextInvInstr;
	logic      nextRegWrite;
	logic      nextCsRegWrite;
	logic      nextMemWrite;
	logic      nextMemRead;
	origAT     nextOrigA;
	origBT     nextOrigB;
	aluOpT     nextAluControl;
	mem2RegT   nextMem2Reg;
	origPcT    nextOrigPc;
	instrTypeT nextInstrType;

	// Decode in ID
	OpcodeDecoder OpcodeDecoder_inst
	(
		.instr      (instr),
		.ecall      (nextEcall),
		.ebreak     (nextEbreak),
		.invInstr   (nextInvInstr),
		.regWrite   (nextRegWrite),
		.csRegWrite (nextCsRegWrite),
		.memWrite   (nextMemWrite),
		.memRead    (nextMemRead),
		.origA      (nextOrigA),
		.origB      (nextOrigB),
		.aluControl (nextAluControl),
		.mem2Reg    (nextMem2Reg),
		.origPc     (nextOrigPc),
		.instrType  (nextInstrType)
	);

	// ID/EX stage
	ControlRegister ControlRegister_inst
	(
		.clock          (clock),
		.reset          (reset),
		.nextEcall      (nextEcall),
		.nextEbreak     (nextEbreak),
		.nextInvInstr   (nextInvInstr),
		.nextRegWrite   (nextRegWrite),
		.nextCsRegWrite (nextCsRegWrite),
		.nextMemWrite   (nextMemWrite),
		.nextMemRead    (nextMemRead),
		.nextOrigA      (nextOrigA),
		.nextOrigB      (nextOrigB),
		.nextAluControl (nextAluControl),
		.nextMem2Reg    (nextMem2Reg),
		.nextOrigPc     (nextOrigPc),
		.nextInstrType  (nextInstrType),
		.ecall          (ecall),
		.ebreak         (ebreak),
		.invInstr       (invInstr),
		.regWrite       (regWrite),
		.csRegWrite     (csRegWrite),
		.memWrite       (memWrite),
		.memRead        (memRead),
		.origA          (origA),
		.origB          (origB),
		.aluControl     (aluControl),
		.mem2Reg        (mem2Reg),
		.origPc         (origPc),
		.instrType      (instrType)
	);

endmodule

// ==== logic/ControlRegister.sv ====
`timescale 1ns/1ps

module ControlRegister
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  nextEcall,
	input  logic                  nextEbreak,
	input  logic                  nextInvInstr,
	input  logic                  nextRegWrite,
	input  logic                  nextCsRegWrite,
	input  logic                  nextMemWrite,
	input  logic                  nextMemRead,
	input  ControlPkg::origAT     nextOrigA,
	input  ControlPkg::origBT     nextOrigB,
	input  ControlPkg::aluOpT     nextAluControl,
	input  ControlPkg::mem2RegT   nextMem2Reg,
	input  ControlPkg::origPcT    nextOrigPc,
	input  ControlPkg::instrTypeT nextInstrType,
	output logic                  ecall,
	output logic                  ebreak,
	output logic                  invInstr,
	output logic                  regWrite,
	output logic                  csRegWrite,
	output logic                  memWrite,
	output logic                  memRead,
	output ControlPkg::origAT     origA,
	output ControlPkg::origBT     origB,
	output ControlPkg::aluOpT     aluControl,
	output ControlPkg::mem2RegT   mem2Reg,
	output ControlPkg::origPcT    origPc,
	output ControlPkg::instrTypeT instrType
);
	import ControlPkg::*;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ecall      <= 1'b0;
			ebreak     <= 1'b0;
			invInstr   <= 1'b0;
			regWrite   <= 1'b0;
			csRegWrite <= 1'b0;
			memWrite   <= 1'b0;
			memRead    <= 1'b0;
			origA      <= ORIGA_RS1;
			origB      <= ORIGB_RS2;
			aluControl <= OPNULL; // Bubble in EX
			mem2Reg    <= MEM2REG_ALU;
			origPc     <= ORIGPC_NEXT;
			instrType  <= '0;
		end
		else
		begin
			ecall      <= nextEcall;
			ebreak     <= nextEbreak;
			invInstr   <= nextInvInstr;
			regWrite   <= nextRegWrite;
			csRegWrite <= nextCsRegWrite;
			memWrite   <= nextMemWrite;
			memRead    <= nextMemRead;
			origA      <= nextOrigA;
			origB      <= nextOrigB;
			aluControl <= nextAluControl;
			mem2Reg    <= nextMem2Reg;
			origPc     <= nextOrigPc;
			instrType  <= nextInstrType;
		end
	end

	// A single access per instruction
	memAccessExclusive: assert property (@(posedge clock) disable iff (reset)
		!(memRead && memWrite));

	invNoWrites: assert property (@(posedge clock) disable iff (reset)
		invInstr |-> !(regWrite || csRegWrite || memWrite));

	trapFlagsExclusive: assert property (@(posedge clock) disable iff (reset)
		$onehot0({ecall, ebreak, invInstr}));

endmodule

// ==== logic/OpcodeDecoder.sv ====
`timescale 1ns/1ps

module OpcodeDecoder
(
	input  ControlPkg::instrT     instr,
	output logic                  ecall,
	output logic                  ebreak,
	output logic                  invInstr,
	output logic                  regWrite,
	output logic                  csRegWrite,
	output logic                  memWrite,
	output logic                  memRead,
	output ControlPkg::origAT     origA,
	output ControlPkg::origBT     origB,
	output ControlPkg::aluOpT     aluControl,
	output ControlPkg::mem2RegT   mem2Reg,
	output ControlPkg::origPcT    origPc,
	output ControlPkg::instrTypeT instrType
);
	import ControlPkg::*;

	opcodeT opcode;
	funct3T funct3;
	funct7T funct7;
	logic   isImm;
	aluOpT  opAluControl;
	logic   mulDiv;
	logic   opInvalid;
	logic   sysEcall;
	logic   sysEbreak;
	logic   sysInvalid;
	logic   sysCsRegWrite;
	origAT  sysOrigA;
	origBT  sysOrigB;
	aluOpT  sysAluControl;
	origPcT sysOrigPc;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign isImm  = (opcode == OPC_OPIMM);

	AluOpDecoder AluOpDecoder_inst
	(
		.funct3     (funct3),
		.funct7     (funct7),
		.isImm      (isImm),
		.aluControl (opAluControl),
		.mulDiv     (mulDiv),
		.opInvalid  (opInvalid)
	);

	SystemDecoder SystemDecoder_inst
	(
		.instr      (instr),
		.ecall      (sysEcall),
		.ebreak     (sysEbreak),
		.sysInvalid (sysInvalid),
		.csRegWrite (sysCsRegWrite),
		.origA      (sysOrigA),
		.origB      (sysOrigB),
		.aluControl (sysAluControl),
		.origPc     (sysOrigPc)
	);

	always_comb
	begin
		ecall      = 1'b0;
		ebreak     = 1'b0;
		invInstr   = 1'b0;
		regWrite   = 1'b0;
		csRegWrite = 1'b0;
		memWrite   = 1'b0;
		memRead    = 1'b0;
		origA      = ORIGA_RS1;
		origB      = ORIGB_RS2;
		aluControl = OPNULL;
		mem2Reg    = MEM2REG_ALU;
		origPc     = ORIGPC_NEXT;
		instrType  = '0;
		case (opcode)
			OPC_LOAD:
			begin
				regWrite                = 1'b1;
				memRead                 = 1'b1;
				origB                   = ORIGB_IMM;
				aluControl              = OPADD; // Address = rs1 + offset
				mem2Reg                 = MEM2REG_MEM;
				instrType[ITYPE_LOAD]   = 1'b1;
			end
			OPC_STORE:
			begin
				memWrite                = 1'b1;
				origB                   = ORIGB_IMM;
				aluControl              = OPADD;
				instrType[ITYPE_STORE]  = 1'b1;
			end
			OPC_LUI:
			begin
				regWrite                = 1'b1;
				origB                   = ORIGB_IMM;
				aluControl              = OPLUI;
				instrType[ITYPE_TIPOI]  = 1'b1;
			end
			OPC_AUIPC:
			begin
				regWrite                = 1'b1;
				origA                   = ORIGA_PC;
				origB                   = ORIGB_IMM;
				aluControl              = OPADD;
				instrType[ITYPE_TIPOI]  = 1'b1;
			end
			OPC_BRANCH:
			begin
				aluControl              = OPADD;
				origPc                  = ORIGPC_BRANCH;
				instrType[ITYPE_BRANCH] = 1'b1;
			end
			OPC_JAL:
			begin
				regWrite                = 1'b1;
				aluControl              = OPADD;
				mem2Reg                 = MEM2REG_PC4; // Link address
				origPc                  = ORIGPC_JAL;
				instrType[ITYPE_JAL]    = 1'b1;
			end
			OPC_JALR:
			begin
				regWrite                = 1'b1;
				aluControl              = OPADD;
				mem2Reg                 = MEM2REG_PC4;
				origPc                  = ORIGPC_JALR;
				instrType[ITYPE_JALR]   = 1'b1;
			end
			OPC_OPIMM, OPC_RTYPE:
			begin
				invInstr                = opInvalid;
				regWrite                = 1'b1;
				origB                   = isImm ? ORIGB_IMM : ORIGB_RS2;
				aluControl              = opAluControl;
				instrType[ITYPE_TIPOI]  = isImm;
				instrType[ITYPE_TIPOR]  = !isImm;
				instrType[ITYPE_DIVREM] = mulDiv;
			end
			OPC_SYSTEM:
			begin
				invInstr                = sysInvalid;
				ecall                   = sysEcall;
				ebreak                  = sysEbreak;
				regWrite                = sysCsRegWrite; // Old CSR value goes to rd
				csRegWrite              = sysCsRegWrite;
				origA                   = sysOrigA;
				origB                   = sysOrigB;
				aluControl              = sysAluControl;
				mem2Reg                 = sysCsRegWrite ? MEM2REG_CSR : MEM2REG_ALU;
				origPc                  = sysOrigPc;
				instrType[ITYPE_CSR]    = sysCsRegWrite;
			end
			default: invInstr = 1'b1;
		endcase

		// Bad encodings leave nothing but the flag
		if (invInstr)
		begin
			ecall      = 1'b0;
			ebreak     = 1'b0;
			regWrite   = 1'b0;
			csRegWrite = 1'b0;
			memWrite   = 1'b0;
			memRead    = 1'b0;
			origA      = ORIGA_RS1;
			origB      = ORIGB_RS2;
			aluControl = OPNULL;
			mem2Reg    = MEM2REG_ALU;
			origPc     = ORIGPC_NEXT;
			instrType  = '0;
		end
	end

endmodule

// ==== logic/AluOpDecoder.sv ====
`timescale 1ns/1ps

module AluOpDecoder
(
	input  ControlPkg::funct3T funct3,
	input  ControlPkg::funct7T funct7,
	input  logic               isImm,
	output ControlPkg::aluOpT  aluControl,
	output logic               mulDiv,
	output logic               opInvalid
);
	import ControlPkg::*;

	logic altFunct;

	// Bit 30 pattern for SUB and SRA
	assign altFunct = (funct7 == FUNCT7_SUB);

	// Immediates fill funct7 in OP-IMM, so only OP can be M or bad
	assign mulDiv    = !isImm && (funct7 == FUNCT7_MULDIV);
	assign opInvalid = !isImm && !mulDiv && !altFunct && (funct7 != FUNCT7_ADD);

	always_comb
	begin
		aluControl = OPNULL;
		if (mulDiv)
		begin
			case (funct3)
				FUNCT3_MUL:    aluControl = OPMUL;
				FUNCT3_MULH:   aluControl = OPMULH;
				FUNCT3_MULHSU: aluControl = OPMULHSU;
				FUNCT3_MULHU:  aluControl = OPMULHU;
				FUNCT3_DIV:    aluControl = OPDIV;
				FUNCT3_DIVU:   aluControl = OPDIVU;
				FUNCT3_REM:    aluControl = OPREM;
				FUNCT3_REMU:   aluControl = OPREMU;
				default:       aluControl = OPNULL;
			endcase
		end
		else
		begin
			case (funct3)
				FUNCT3_ADD:
				begin
					if (altFunct && !isImm)
						aluControl = OPSUB;
					else
						aluControl = OPADD; // ADDI ignores the upper bits
				end
				FUNCT3_SLL:  aluControl = OPSLL;
				FUNCT3_SLT:  aluControl = OPSLT;
				FUNCT3_SLTU: aluControl = OPSLTU;
				FUNCT3_XOR:  aluControl = OPXOR;
				FUNCT3_SRL:
				begin
					if (altFunct)
						aluControl = OPSRA; // SRA and SRAI
					else
						aluControl = OPSRL;
				end
				FUNCT3_OR:   aluControl = OPOR;
				FUNCT3_AND:  aluControl = OPAND;
				default:     aluControl = OPNULL;
			endcase
		end
	end

endmodule

// ==== logic/SystemDecoder.sv ====
`timescale 1ns/1ps

module SystemDecoder
(
	input  ControlPkg::instrT  instr,
	output logic               ecall,
	output logic               ebreak,
	output logic               sysInvalid,
	output logic               csRegWrite,
	output ControlPkg::origAT  origA,
	output ControlPkg::origBT  origB,
	output ControlPkg::aluOpT  aluControl,
	output ControlPkg::origPcT origPc
);
	import ControlPkg::*;

	funct3T  funct3;
	funct12T funct12;

	assign funct3  = instr[14:12];
	assign funct12 = instr[31:20]; // funct7 and rs2 together

	always_comb
	begin
		ecall      = 1'b0;
		ebreak     = 1'b0;
		sysInvalid = 1'b0;
		csRegWrite = 1'b0;
		origA      = ORIGA_RS1;
		origB      = ORIGB_RS2;
		aluControl = OPNULL;
		origPc     = ORIGPC_NEXT;
		case (funct3)
			FUNCT3_PRIV:
			begin
				case (funct12)
					FUNCT12_ECALL:
					begin
						ecall  = 1'b1;
						origPc = ORIGPC_UTVEC; // Trap vector
					end
					FUNCT12_EBREAK: ebreak = 1'b1;
					FUNCT12_URET:   origPc = ORIGPC_UEPC;
					default:        sysInvalid = 1'b1;
				endcase
			end
			FUNCT3_CSRRW, FUNCT3_CSRRWI:
			begin
				csRegWrite = 1'b1;
				origA      = (funct3 == FUNCT3_CSRRWI) ? ORIGA_IMM : ORIGA_RS1;
				origB      = ORIGB_ZERO; // Pass A straight through
				aluControl = OPADD;
			end
			FUNCT3_CSRRS, FUNCT3_CSRRSI:
			begin
				csRegWrite = 1'b1;
				origA      = (funct3 == FUNCT3_CSRRSI) ? ORIGA_IMM : ORIGA_RS1;
				aluControl = OPOR; // Set bits of the CSR value
			end
			FUNCT3_CSRRC, FUNCT3_CSRRCI:
			begin
				csRegWrite = 1'b1;
				origA      = (funct3 == FUNCT3_CSRRCI) ? ORIGA_IMM : ORIGA_NOTRS1;
				aluControl = OPAND;
			end
			default: sysInvalid = 1'b1;
		endcase
	end

endmodule

// ==== logic/ControlPkg.sv ====
package ControlPkg;

	// Instruction fields
	typedef logic [31:0] instrT;
	typedef logic [6:0]  opcodeT;
	typedef logic [2:0]  funct3T;
	typedef logic [6:0]  funct7T;
	typedef logic [11:0] funct12T;

	// Datapath control fields
	typedef logic [4:0] aluOpT;
	typedef logic [1:0] origAT;
	typedef logic [1:0] origBT;
	typedef logic [2:0] mem2RegT;
	typedef logic [2:0] origPcT;

	localparam int NTYPE = 9;
	typedef logic [NTYPE-1:0] instrTypeT;

	// RV32 base opcodes
	localparam opcodeT OPC_SYSTEM = 7'b1110011;
	localparam opcodeT OPC_LOAD   = 7'b0000011;
	localparam opcodeT OPC_OPIMM  = 7'b0010011;
	localparam opcodeT OPC_AUIPC  = 7'b0010111;
	localparam opcodeT OPC_STORE  = 7'b0100011;
	localparam opcodeT OPC_RTYPE  = 7'b0110011;
	localparam opcodeT OPC_LUI    = 7'b0110111;
	localparam opcodeT OPC_BRANCH = 7'b1100011;
	localparam opcodeT OPC_JALR   = 7'b1100111;
	localparam opcodeT OPC_JAL    = 7'b1101111;

	// Integer ALU funct3
	localparam funct3T FUNCT3_ADD  = 3'b000;
	localparam funct3T FUNCT3_SLL  = 3'b001;
	localparam funct3T FUNCT3_SLT  = 3'b010;
	localparam funct3T FUNCT3_SLTU = 3'b011;
	localparam funct3T FUNCT3_XOR  = 3'b100;
	localparam funct3T FUNCT3_SRL  = 3'b101; // Shared with SRA
	localparam funct3T FUNCT3_OR   = 3'b110;
	localparam funct3T FUNCT3_AND  = 3'b111;

	// M extension funct3
	localparam funct3T FUNCT3_MUL    = 3'b000;
	localparam funct3T FUNCT3_MULH   = 3'b001;
	localparam funct3T FUNCT3_MULHSU = 3'b010;
	localparam funct3T FUNCT3_MULHU  = 3'b011;
	localparam funct3T FUNCT3_DIV    = 3'b100;
	localparam funct3T FUNCT3_DIVU   = 3'b101;
	localparam funct3T FUNCT3_REM    = 3'b110;
	localparam funct3T FUNCT3_REMU   = 3'b111;

	// SYSTEM funct3, 3'b100 is unused
	localparam funct3T FUNCT3_PRIV   = 3'b000;
	localparam funct3T FUNCT3_CSRRW  = 3'b001;
	localparam funct3T FUNCT3_CSRRS  = 3'b010;
	localparam funct3T FUNCT3_CSRRC  = 3'b011;
	localparam funct3T FUNCT3_CSRRWI = 3'b101;
	localparam funct3T FUNCT3_CSRRSI = 3'b110;
	localparam funct3T FUNCT3_CSRRCI = 3'b111;

	localparam funct7T FUNCT7_ADD    = 7'b0000000;
	localparam funct7T FUNCT7_SUB    = 7'b0100000; // Also SRA
	localparam funct7T FUNCT7_MULDIV = 7'b0000001;

	localparam funct12T FUNCT12_ECALL  = 12'h000;
	localparam funct12T FUNCT12_EBREAK = 12'h001;
	localparam funct12T FUNCT12_URET   = 12'h002;

	// ALU operations
	localparam aluOpT OPNULL   = 5'd0;
	localparam aluOpT OPADD    = 5'd1;
	localparam aluOpT OPSUB    = 5'd2;
	localparam aluOpT OPSLL    = 5'd3;
	localparam aluOpT OPSLT    = 5'd4;
	localparam aluOpT OPSLTU   = 5'd5;
	localparam aluOpT OPXOR    = 5'd6;
	localparam aluOpT OPSRL    = 5'd7;
	localparam aluOpT OPSRA    = 5'd8;
	localparam aluOpT OPOR     = 5'd9;
	localparam aluOpT OPAND    = 5'd10;
	localparam aluOpT OPLUI    = 5'd11;
	localparam aluOpT OPMUL    = 5'd12;
	localparam aluOpT OPMULH   = 5'd13;
	localparam aluOpT OPMULHSU = 5'd14;
	localparam aluOpT OPMULHU  = 5'd15;
	localparam aluOpT OPDIV    = 5'd16;
	localparam aluOpT OPDIVU   = 5'd17;
	localparam aluOpT OPREM    = 5'd18;
	localparam aluOpT OPREMU   = 5'd19;

	localparam origAT ORIGA_RS1    = 2'd0;
	localparam origAT ORIGA_PC     = 2'd1;
	localparam origAT ORIGA_IMM    = 2'd2;
	localparam origAT ORIGA_NOTRS1 = 2'd3;

	localparam origBT ORIGB_RS2  = 2'd0;
	localparam origBT ORIGB_IMM  = 2'd1;
	localparam origBT ORIGB_ZERO = 2'd2;

	localparam mem2RegT MEM2REG_ALU = 3'd0;
	localparam mem2RegT MEM2REG_PC4 = 3'd1;
	localparam mem2RegT MEM2REG_MEM = 3'd2;
	localparam mem2RegT MEM2REG_CSR = 3'd4;

	localparam origPcT ORIGPC_NEXT   = 3'd0;
	localparam origPcT ORIGPC_BRANCH = 3'd1;
	localparam origPcT ORIGPC_JAL    = 3'd2;
	localparam origPcT ORIGPC_JALR   = 3'd3;
	localparam origPcT ORIGPC_UEPC   = 3'd4;
	localparam origPcT ORIGPC_UTVEC  = 3'd5;

	// Bit positions in instrTypeT
	localparam int ITYPE_BRANCH = 0;
	localparam int ITYPE_JALR   = 1;
	localparam int ITYPE_JAL    = 2;
	localparam int ITYPE_TIPOI  = 3;
	localparam int ITYPE_TIPOR  = 4;
	localparam int ITYPE_STORE  = 5;
	localparam int ITYPE_LOAD   = 6;
	localparam int ITYPE_DIVREM = 7;
	localparam int ITYPE_CSR    = 8;

endpackage
